/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module balanceTb \
		-f sources.f -o balanceSim
	./obj_dir/balanceSim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
	cat sim.log
	@if grep -q "Errors found" sim.log; then exit 1; fi
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/angleReceiver.sv */
module angleReceiver
  import balancePkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  serialIn,
  output logic [angleWidth-1:0] angle,
  output logic                  angleValid
);

  // two-flop synchronizer on the serial line
  logic [1:0] syncReg;
  logic rxBit;

  // FSM and bit timing
  logic [1:0] rxState;
  logic [timerWidth-1:0] bitTimer;
  logic [2:0] bitIndex;
  // set while the low byte of a sample is held
  logic highByte;

  // payload
  logic [7:0] shiftReg;
  logic [7:0] lowByte;

  // sample points
  logic sampleData;
  logic sampleStop;
  logic stopOk;

  assign rxBit = syncReg[1];

  assign sampleData = (rxState == rxData) && (bitTimer == bitLast);
  assign sampleStop = (rxState == rxStop) && (bitTimer == bitLast);
  assign stopOk = sampleStop && rxBit;

  // idle line is high, so the synchronizer resets to ones
  always_ff @(posedge clk) begin
    if (rst) begin
      syncReg <= 2'b11;
    end else begin
      syncReg <= {syncReg[0], serialIn};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rxState <= rxIdle;
      bitTimer <= '0;
      bitIndex <= '0;
      highByte <= 1'b0;
      angleValid <= 1'b0;
    end else begin
      // strobe lasts one cycle
      angleValid <= 1'b0;
      case (rxState)
        rxIdle: begin
          bitTimer <= '0;
          // falling edge means a start bit
          if (!rxBit) begin
            rxState <= rxStart;
          end
        end
        rxStart: begin
          if (bitTimer == bitHalf) begin
            bitTimer <= '0;
            bitIndex <= '0;
            // glitch filter, start bit must still be low at mid-bit
            rxState <= rxBit ? rxIdle : rxData;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        rxData: begin
          if (sampleData) begin
            bitTimer <= '0;
            bitIndex <= bitIndex + 1'b1;
            if (bitIndex == 3'd7) begin
              rxState <= rxStop;
            end
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        rxStop: begin
          if (sampleStop) begin
            bitTimer <= '0;
            // back to idle at mid stop bit, line is high there
            rxState <= rxIdle;
            if (stopOk) begin
              highByte <= !highByte;
              angleValid <= highByte;
            end else begin
              // framing error, resync on a low byte
              highByte <= 1'b0;
            end
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        default: rxState <= rxIdle;
      endcase
    end
  end

  // data path, LSB arrives first
  always_ff @(posedge clk) begin
    if (sampleData) begin
      shiftReg <= {rxBit, shiftReg[7:1]};
    end
    if (stopOk && !highByte) begin
      lowByte <= shiftReg;
    end
    // held stable until the next sample completes
    if (stopOk && highByte) begin
      angle <= {shiftReg, lowByte};
    end
  end

endmodule

/* logic/balancePkg.sv */
package balancePkg;

  // angle, error integral and motor power share one word size
  localparam int angleWidth = 16;

  // upright position in sensor units
  localparam logic signed [angleWidth-1:0] targetAngle = 16'sd180;

  // integer PID gains
  localparam logic signed [angleWidth-1:0] kp = 16'sd4;
  localparam logic signed [angleWidth-1:0] ki = 16'sd1;
  localparam logic signed [angleWidth-1:0] kd = 16'sd2;

  // integral clamp, symmetric around zero
  localparam logic signed [angleWidth-1:0] sumLimit = 16'sd1023;

  // motor power saturation bounds
  localparam logic signed [angleWidth-1:0] powerMax = 16'sh7fff;
  localparam logic signed [angleWidth-1:0] powerMin = 16'sh8000;

  // serial bit period in clocks
  localparam int clksPerBit = 8;
  localparam int timerWidth = $clog2(clksPerBit);
  // last tick of a bit, and the tick at mid-bit of the start bit
  localparam logic [timerWidth-1:0] bitLast = timerWidth'(clksPerBit - 1);
  localparam logic [timerWidth-1:0] bitHalf = timerWidth'(clksPerBit / 2 - 1);

  // receiver FSM state codes
  localparam logic [1:0] rxIdle  = 2'd0;
  localparam logic [1:0] rxStart = 2'd1;
  localparam logic [1:0] rxData  = 2'd2;
  localparam logic [1:0] rxStop  = 2'd3;

  // PWM resolution and top duty
  localparam int dutyWidth = 10;
  localparam logic [dutyWidth-1:0] dutyMax = 10'd1023;

  // motor bridge direction codes
  localparam logic [1:0] dirStop     = 2'b00;
  localparam logic [1:0] dirForward  = 2'b01;
  localparam logic [1:0] dirBackward = 2'b10;

endpackage

/* logic/balanceTop.sv */
module balanceTop
  import balancePkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 serialIn,
  output logic           [1:0] leftDirection,
  output logic           [1:0] rightDirection,
  output logic                 leftPwm,
  output logic                 rightPwm,
  output logic [dutyWidth-1:0] duty
);

  // receiver to controller
  logic [angleWidth-1:0] angle;
  logic angleValid;

  // controller to driver
  logic signed [angleWidth-1:0] motorPower;
  logic powerValid;

  // decode
  angleReceiver angleRx (
    .clk        (clk),
    .rst        (rst),
    .serialIn   (serialIn),
    .angle      (angle),
    .angleValid (angleValid)
  );

  // execute
  pidController pid (
    .clk        (clk),
    .rst        (rst),
    .angle      (angle),
    .angleValid (angleValid),
    .motorPower (motorPower),
    .powerValid (powerValid)
  );

  // result
  motorDriver motor (
    .clk            (clk),
    .rst            (rst),
    .motorPower     (motorPower),
    .powerValid     (powerValid),
    .leftDirection  (leftDirection),
    .rightDirection (rightDirection),
    .leftPwm        (leftPwm),
    .rightPwm       (rightPwm),
    .duty           (duty)
  );

endmodule

/* logic/motorDriver.sv */
module motorDriver
  import balancePkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic signed [angleWidth-1:0] motorPower,
  input  logic                         powerValid,
  output logic                  [1:0]  leftDirection,
  output logic                  [1:0]  rightDirection,
  output logic                         leftPwm,
  output logic                         rightPwm,
  output logic        [dutyWidth-1:0]  duty
);

  // one extra bit so that -32768 has a magnitude
  logic [angleWidth:0] powerWide;
  logic [angleWidth:0] magnitude;
  logic [dutyWidth-1:0] dutyNext;
  logic [1:0] dirNext;

  // both wheels share one command
  logic [1:0] direction;
  logic [dutyWidth-1:0] pwmCount;
  logic pwmOut;

  always_comb begin
    powerWide = {motorPower[angleWidth-1], motorPower};
    // two's complement absolute value
    magnitude = powerWide[angleWidth] ? (~powerWide + 1'b1) : powerWide;

    if (magnitude > (angleWidth + 1)'(dutyMax)) begin
      dutyNext = dutyMax;
    end else begin
      dutyNext = magnitude[dutyWidth-1:0];
    end

    // sign to direction code
    if (motorPower < 0) begin
      dirNext = dirBackward;
    end else if (motorPower == 0) begin
      dirNext = dirStop;
    end else begin
      dirNext = dirForward;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      direction <= dirStop;
      duty <= '0;
      pwmCount <= '0;
      pwmOut <= 1'b0;
    end else begin
      // command changes only on a new power sample
      if (powerValid) begin
        direction <= dirNext;
        duty <= dutyNext;
      end
      // free-running period of 1024 clocks
      pwmCount <= pwmCount + 1'b1;
      pwmOut <= (pwmCount < duty);
    end
  end

  assign leftDirection = direction;
  assign rightDirection = direction;
  assign leftPwm = pwmOut;
  assign rightPwm = pwmOut;

endmodule

/* logic/pidController.sv */
module pidController
  import balancePkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic        [angleWidth-1:0] angle,
  input  logic                         angleValid,
  output logic signed [angleWidth-1:0] motorPower,
  output logic                         powerValid
);

  // state kept between samples
  logic signed [angleWidth-1:0] prevAngle;
  logic signed [angleWidth-1:0] errorSum;

  // 32-bit working values
  logic signed [31:0] errorFull;
  logic signed [31:0] derivative;
  logic signed [31:0] sumRaw;
  logic signed [31:0] sumClamped;
  logic signed [31:0] pTerm;
  logic signed [31:0] iTerm;
  logic signed [31:0] dTerm;
  logic signed [31:0] powerSum;
  logic signed [angleWidth-1:0] powerSat;

  always_comb begin
    // error and derivative keep full precision, no 16-bit wrap
    errorFull = $signed(angle) - targetAngle;
    // one strobe per sample period, so no divide by time
    derivative = $signed(angle) - prevAngle;

    // integral with symmetric clamp
    sumRaw = errorSum + errorFull;
    if (sumRaw > sumLimit) begin
      sumClamped = sumLimit;
    end else if (sumRaw < -sumLimit) begin
      sumClamped = -sumLimit;
    end else begin
      sumClamped = sumRaw;
    end

    pTerm = kp * errorFull;
    // integral term uses the updated sum
    iTerm = ki * sumClamped;
    dTerm = kd * derivative;
    powerSum = pTerm + iTerm + dTerm;

    // saturate to the 16-bit power range
    if (powerSum > powerMax) begin
      powerSat = powerMax;
    end else if (powerSum < powerMin) begin
      powerSat = powerMin;
    end else begin
      powerSat = powerSum[angleWidth-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // first derivative is measured from upright
      prevAngle <= targetAngle;
      errorSum <= '0;
      powerValid <= 1'b0;
    end else begin
      powerValid <= angleValid;
      if (angleValid) begin
        prevAngle <= $signed(angle);
        errorSum <= sumClamped[angleWidth-1:0];
      end
    end
  end

  // registered output, valid alongside powerValid
  always_ff @(posedge clk) begin
    if (angleValid) begin
      motorPower <= powerSat;
    end
  end

endmodule

/* sources.f */
logic/balancePkg.sv
logic/angleReceiver.sv
logic/pidController.sv
logic/motorDriver.sv
logic/balanceTop.sv
test/balance_props.sv
test/balanceTb.sv

/* test/balanceTb.sv */
module balanceTb
  import balancePkg::*;
();

  localparam int randomFrames = 40;
  localparam int clampFrames = 30;
  // random stream, two clamp runs with release, saturation, PWM, framing
  localparam int totalFrames = randomFrames + 2 * (clampFrames + 1) + 2 + 1 + 3;
  // two bytes of ten bits, each followed by one idle bit
  localparam int cycleLimit = totalFrames * 22 * clksPerBit + 5000;

  logic clk;
  logic rst;
  logic serialIn;
  logic [1:0] leftDirection;
  logic [1:0] rightDirection;
  logic leftPwm;
  logic rightPwm;
  logic [dutyWidth-1:0] duty;

  int errorCount;
  int checkCount;
  int cycleCount;

  // reference model state
  int modelPrev;
  int modelSum;
  int modelDuty;
  logic [1:0] modelDir;

  balanceTop i_dut (
    .clk            (clk),
    .rst            (rst),
    .serialIn       (serialIn),
    .leftDirection  (leftDirection),
    .rightDirection (rightDirection),
    .leftPwm        (leftPwm),
    .rightPwm       (rightPwm),
    .duty           (duty)
  );

  // assertions over the whole control path
  bind balanceTop balanceProps pathProps (
    .clk            (clk),
    .rst            (rst),
    .angleValid     (angleValid),
    .powerValid     (powerValid),
    .leftDirection  (leftDirection),
    .rightDirection (rightDirection),
    .leftPwm        (leftPwm),
    .rightPwm       (rightPwm)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      $display("Errors found");
      $finish;
    end
  end

  task automatic checkValue(input string name, input int expected, input int actual);
    checkCount++;
    if (expected != actual) begin
      errorCount++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // one 8N1 byte, then an idle bit so the receiver is back in idle
  task automatic sendByte(input logic [7:0] data, input logic stopBit);
    logic [9:0] bits;
    int i;
    bits = {stopBit, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      serialIn <= bits[i];
      repeat (clksPerBit - 1) @(posedge clk);
    end
    @(posedge clk);
    serialIn <= 1'b1;
    repeat (clksPerBit - 1) @(posedge clk);
  endtask

  // low byte first and a selectable stop bit on the high byte
  task automatic sendFrame(input logic [15:0] value, input logic highStop);
    sendByte(value[7:0], 1'b1);
    sendByte(value[15:8], highStop);
  endtask

  // PID and driver rules in integer arithmetic
  task automatic updateModel(input logic [15:0] value);
    int sample;
    int err;
    int deriv;
    int power;
    int mag;
    sample = int'($signed(value));
    err = sample - int'(targetAngle);
    deriv = sample - modelPrev;
    modelSum = modelSum + err;
    if (modelSum > int'(sumLimit)) begin
      modelSum = int'(sumLimit);
    end else if (modelSum < -int'(sumLimit)) begin
      modelSum = -int'(sumLimit);
    end
    power = int'(kp) * err + int'(ki) * modelSum + int'(kd) * deriv;
    if (power > int'(powerMax)) begin
      power = int'(powerMax);
    end else if (power < int'(powerMin)) begin
      power = int'(powerMin);
    end
    modelPrev = sample;
    // sign picks the direction, magnitude the duty
    if (power < 0) begin
      modelDir = dirBackward;
      mag = -power;
    end else if (power == 0) begin
      modelDir = dirStop;
      mag = 0;
    end else begin
      modelDir = dirForward;
      mag = power;
    end
    modelDuty = (mag > int'(dutyMax)) ? int'(dutyMax) : mag;
  endtask

  // outputs settled well before the frame's idle bit ends
  task automatic checkOutputs(input string name);
    @(negedge clk);
    checkValue({name, " duty"}, modelDuty, int'(duty));
    checkValue({name, " leftDirection"}, int'(modelDir), int'(leftDirection));
    checkValue({name, " rightDirection"}, int'(modelDir), int'(rightDirection));
  endtask

  task automatic applyFrame(input string name, input logic [15:0] value);
    sendFrame(value, 1'b1);
    updateModel(value);
    checkOutputs(name);
  endtask

  // a third near upright, the rest anywhere
  function automatic logic [15:0] randomAngle();
    int offset;
    logic [15:0] value;
    if ($urandom % 3 == 0) begin
      offset = int'($urandom % 64) - 32;
      value = 16'(int'(targetAngle) + offset);
    end else begin
      value = 16'($urandom);
    end
    return value;
  endfunction

  // one full PWM period of 1024 cycles on both wheels
  task automatic countPwm(input string name);
    int highCycles;
    int rightCycles;
    int i;
    highCycles = 0;
    rightCycles = 0;
    for (i = 0; i < 1024; i++) begin
      @(negedge clk);
      if (leftPwm) begin
        highCycles++;
      end
      if (rightPwm) begin
        rightCycles++;
      end
    end
    checkValue({name, " left"}, modelDuty, highCycles);
    checkValue({name, " right"}, modelDuty, rightCycles);
  endtask

  // hold one side long enough to hit the integral clamp
  task automatic runClamp(input string name, input int offset);
    int i;
    for (i = 0; i < clampFrames; i++) begin
      applyFrame(name, 16'(int'(targetAngle) + offset));
    end
    // at target the clamped integral minus the step shows up in duty
    applyFrame({name, " release"}, targetAngle);
  endtask

  task automatic checkReset();
    int i;
    @(negedge clk);
    checkValue("reset duty", 0, int'(duty));
    checkValue("reset leftDirection", int'(dirStop), int'(leftDirection));
    checkValue("reset rightDirection", int'(dirStop), int'(rightDirection));
    for (i = 0; i < 32; i++) begin
      @(negedge clk);
      checkValue("reset leftPwm", 0, int'(leftPwm));
      checkValue("reset rightPwm", 0, int'(rightPwm));
    end
  endtask

  initial begin
    int i;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    modelPrev = int'(targetAngle);
    modelSum = 0;
    modelDuty = 0;
    modelDir = dirStop;
    rst = 1'b1;
    serialIn = 1'b1;
    void'($urandom(32'hab1d));

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    checkReset();

    // mid-range duty of 4*60 + 60 + 2*60
    applyFrame("pwm", 16'(int'(targetAngle) + 60));
    countPwm("pwm high cycles");

    for (i = 0; i < randomFrames; i++) begin
      applyFrame("random", randomAngle());
    end

    runClamp("clamp high", 200);
    runClamp("clamp low", -200);

    // extremes saturate the power
    applyFrame("saturate positive", 16'h7fff);
    checkValue("saturate positive max duty", int'(dutyMax), int'(duty));
    checkValue("saturate positive forward", int'(dirForward), int'(leftDirection));
    applyFrame("saturate negative", 16'h8000);
    checkValue("saturate negative max duty", int'(dutyMax), int'(duty));
    checkValue("saturate negative backward", int'(dirBackward), int'(leftDirection));

    // bad stop bit leaves the model and the outputs alone
    applyFrame("framing before", 16'(int'(targetAngle) - 40));
    sendFrame(16'(int'(targetAngle) + 90), 1'b0);
    checkOutputs("framing discarded");
    applyFrame("framing after", 16'(int'(targetAngle) + 25));

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* test/balance_props.sv */
module balanceProps (
  input logic       clk,
  input logic       rst,
  input logic       angleValid,
  input logic       powerValid,
  input logic [1:0] leftDirection,
  input logic [1:0] rightDirection,
  input logic       leftPwm,
  input logic       rightPwm
);

  // controller answers every sample one cycle later
  powerFollowsAngle: assert property (
    @(posedge clk) disable iff (rst) angleValid |=> powerValid
  ) else $error("powerValid missing one cycle after angleValid");

  // no power strobe without a sample before it
  powerHasSample: assert property (
    @(posedge clk) disable iff (rst) powerValid |-> $past(angleValid)
  ) else $error("powerValid raised without angleValid in the cycle before");

  // strobes are single-cycle pulses
  angleSingle: assert property (
    @(posedge clk) disable iff (rst) angleValid |=> !angleValid
  ) else $error("angleValid high for two cycles in a row");

  powerSingle: assert property (
    @(posedge clk) disable iff (rst) powerValid |=> !powerValid
  ) else $error("powerValid high for two cycles in a row");

  // code 11 would short the bridge
  leftDirLegal: assert property (
    @(posedge clk) disable iff (rst) leftDirection != 2'b11
  ) else $error("leftDirection took the illegal code 11");

  rightDirLegal: assert property (
    @(posedge clk) disable iff (rst) rightDirection != 2'b11
  ) else $error("rightDirection took the illegal code 11");

  // both wheels get the same PWM
  pwmMatch: assert property (
    @(posedge clk) disable iff (rst) leftPwm == rightPwm
  ) else $error("leftPwm and rightPwm differ");

endmodule
